/* cpu_core.f */
logic/cpu_pkg.sv
logic/cpu_fetch.sv
logic/cpu_register_file.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/cpu_memory.sv
logic/cpu_core.sv
verif/cpu_core_tb.sv

/* logic/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
	parameter int XLEN  = 32,
	parameter int TAG_W = 8
) (
	input  logic            i_clock,
	input  logic            i_rst_n,
	input  logic            i_hold,
	output logic [XLEN-1:0] o_imem_addr,
	input  logic [31:0]     i_imem_data,
	output logic            o_dmem_read,
	output logic            o_dmem_write,
	output logic [2:0]      o_dmem_width,
	output logic [XLEN-1:0] o_dmem_addr,
	output logic [XLEN-1:0] o_dmem_wdata,
	input  logic [XLEN-1:0] i_dmem_rdata,
	output logic            o_retire,
	output logic [XLEN-1:0] o_retire_pc,
	output logic [4:0]      o_retire_rd,
	output logic [XLEN-1:0] o_retire_value
);
	// ========================================================================
	// Stage wires
	// ========================================================================
	logic [TAG_W-1:0] f_tag;
	logic [XLEN-1:0]  f_pc;
	logic [31:0]      f_instruction;
	logic [4:0]       rs1_addr;
	logic [4:0]       rs2_addr;
	logic [XLEN-1:0]  rs1_data;
	logic [XLEN-1:0]  rs2_data;
	logic [TAG_W-1:0] d_tag;
	logic [XLEN-1:0]  d_pc;
	logic [31:0]      d_instruction;
	logic [XLEN-1:0]  d_rs1;
	logic [XLEN-1:0]  d_rs2;
	logic [4:0]       d_inst_rd;
	logic [XLEN-1:0]  d_imm;
	logic             d_branch;
	logic [TAG_W-1:0] x_tag;
	logic [4:0]       x_inst_rd;
	logic [XLEN-1:0]  x_rd;
	logic             x_branch;
	logic [XLEN-1:0]  x_pc_next;
	logic             x_mem_read;
	logic             x_mem_write;
	logic [2:0]       x_mem_width;
	logic             x_mem_signed;
	logic [XLEN-1:0]  x_mem_address;
	logic             wb_we;
	logic [4:0]       wb_rd_addr;
	logic [XLEN-1:0]  wb_rd_data;
	logic [XLEN-1:0]  pc_next;

	cpu_fetch #(.XLEN(XLEN), .TAG_W(TAG_W)) u_fetch (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_hold(i_hold),
		.i_retire(o_retire), .i_pc_next(pc_next), .i_imem_data(i_imem_data),
		.o_imem_addr(o_imem_addr), .o_tag(f_tag), .o_pc(f_pc),
		.o_instruction(f_instruction)
	);

	cpu_register_file #(.XLEN(XLEN)) u_register_file (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
		.i_we(wb_we), .i_rd_addr(wb_rd_addr), .i_rd_data(wb_rd_data)
	);

	cpu_decode #(.XLEN(XLEN), .TAG_W(TAG_W)) u_decode (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_hold(i_hold),
		.i_tag(f_tag), .i_pc(f_pc), .i_instruction(f_instruction),
		.o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.o_tag(d_tag), .o_pc(d_pc), .o_instruction(d_instruction),
		.o_rs1(d_rs1), .o_rs2(d_rs2), .o_inst_rd(d_inst_rd),
		.o_imm(d_imm), .o_branch(d_branch)
	);

	cpu_execute #(.XLEN(XLEN), .TAG_W(TAG_W)) u_execute (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_hold(i_hold),
		.i_tag(d_tag), .i_pc(d_pc), .i_instruction(d_instruction),
		.i_rs1(d_rs1), .i_rs2(d_rs2), .i_inst_rd(d_inst_rd),
		.i_imm(d_imm), .i_branch(d_branch),
		.o_tag(x_tag), .o_inst_rd(x_inst_rd), .o_rd(x_rd),
		.o_branch(x_branch), .o_pc_next(x_pc_next),
		.o_mem_read(x_mem_read), .o_mem_write(x_mem_write),
		.o_mem_width(x_mem_width), .o_mem_signed(x_mem_signed),
		.o_mem_address(x_mem_address)
	);

	// Fetch holds the PC of the single instruction in flight.
	cpu_memory #(.XLEN(XLEN), .TAG_W(TAG_W)) u_memory (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_hold(i_hold),
		.i_tag(x_tag), .i_pc(f_pc), .i_inst_rd(x_inst_rd), .i_rd(x_rd),
		.i_branch(x_branch), .i_pc_next(x_pc_next),
		.i_mem_read(x_mem_read), .i_mem_write(x_mem_write),
		.i_mem_width(x_mem_width), .i_mem_signed(x_mem_signed),
		.i_mem_address(x_mem_address),
		.o_dmem_read(o_dmem_read), .o_dmem_write(o_dmem_write),
		.o_dmem_width(o_dmem_width), .o_dmem_addr(o_dmem_addr),
		.o_dmem_wdata(o_dmem_wdata), .i_dmem_rdata(i_dmem_rdata),
		.o_we(wb_we), .o_rd_addr(wb_rd_addr), .o_rd_data(wb_rd_data),
		.o_retire(o_retire), .o_retire_pc(o_retire_pc),
		.o_retire_rd(o_retire_rd), .o_retire_value(o_retire_value),
		.o_pc_next(pc_next)
	);

endmodule

/* logic/cpu_decode.sv */
`timescale 1ns/1ps

module cpu_decode #(
	parameter int XLEN  = 32,
	parameter int TAG_W = 8
) (
	input  logic             i_clock,
	input  logic             i_rst_n,
	input  logic             i_hold,
	input  logic [TAG_W-1:0] i_tag,
	input  logic [XLEN-1:0]  i_pc,
	input  logic [31:0]      i_instruction,
	output logic [4:0]       o_rs1_addr,
	output logic [4:0]       o_rs2_addr,
	input  logic [XLEN-1:0]  i_rs1_data,
	input  logic [XLEN-1:0]  i_rs2_data,
	output logic [TAG_W-1:0] o_tag,
	output logic [XLEN-1:0]  o_pc,
	output logic [31:0]      o_instruction,
	output logic [XLEN-1:0]  o_rs1,
	output logic [XLEN-1:0]  o_rs2,
	output logic [4:0]       o_inst_rd,
	output logic [XLEN-1:0]  o_imm,
	output logic             o_branch
);
	logic [6:0]  opcode;
	logic [31:0] imm32;
	logic [4:0]  rd_field;
	logic        is_branch;
	logic        accept;

	assign opcode     = i_instruction[6:0];
	assign o_rs1_addr = i_instruction[19:15];
	assign o_rs2_addr = i_instruction[24:20];
	assign accept     = !i_hold && (i_tag != o_tag);

	// ========================================================================
	// Immediate by format
	// ========================================================================
	always_comb begin
		case (opcode)
			cpu_pkg::OP_STORE:
				imm32 = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
			cpu_pkg::OP_BRANCH:
				imm32 = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
					i_instruction[30:25], i_instruction[11:8], 1'b0};
			cpu_pkg::OP_LUI, cpu_pkg::OP_AUIPC:
				imm32 = {i_instruction[31:12], 12'b0};
			cpu_pkg::OP_JAL:
				imm32 = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
					i_instruction[20], i_instruction[30:21], 1'b0};
			default:
				imm32 = {{20{i_instruction[31]}}, i_instruction[31:20]};    // I-type.
		endcase
	end

	always_comb begin
		case (opcode)
			cpu_pkg::OP_LUI, cpu_pkg::OP_AUIPC, cpu_pkg::OP_JAL, cpu_pkg::OP_JALR,
			cpu_pkg::OP_LOAD, cpu_pkg::OP_IMM, cpu_pkg::OP_REG:
				rd_field = i_instruction[11:7];
			default:
				rd_field = 5'd0;    // Branches and stores write nothing.
		endcase
	end

	assign is_branch = (opcode == cpu_pkg::OP_BRANCH) || (opcode == cpu_pkg::OP_JAL) ||
		(opcode == cpu_pkg::OP_JALR);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_tag    <= '0;
			o_branch <= 1'b0;
		end else if (accept) begin
			o_tag    <= i_tag;
			o_branch <= is_branch;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_pc          <= i_pc;
			o_instruction <= i_instruction;
			o_rs1         <= i_rs1_data;
			o_rs2         <= i_rs2_data;
			o_inst_rd     <= rd_field;
			o_imm         <= XLEN'(signed'(imm32));
		end
	end

endmodule

/* logic/cpu_execute.sv */
`timescale 1ns/1ps

module cpu_execute #(
	parameter int XLEN  = 32,
	parameter int TAG_W = 8
) (
	input  logic             i_clock,
	input  logic             i_rst_n,
	input  logic             i_hold,
	input  logic [TAG_W-1:0] i_tag,
	input  logic [XLEN-1:0]  i_pc,
	input  logic [31:0]      i_instruction,
	input  logic [XLEN-1:0]  i_rs1,
	input  logic [XLEN-1:0]  i_rs2,
	input  logic [4:0]       i_inst_rd,
	input  logic [XLEN-1:0]  i_imm,
	input  logic             i_branch,
	output logic [TAG_W-1:0] o_tag,
	output logic [4:0]       o_inst_rd,
	output logic [XLEN-1:0]  o_rd,
	output logic             o_branch,
	output logic [XLEN-1:0]  o_pc_next,
	output logic             o_mem_read,
	output logic             o_mem_write,
	output logic [2:0]       o_mem_width,
	output logic             o_mem_signed,
	output logic [XLEN-1:0]  o_mem_address
);
	localparam int SHW = $clog2(XLEN);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            alt;           // Bit 30, SUB and SRA.
	logic [XLEN-1:0] operand_b;
	logic [SHW-1:0]  shamt;
	logic            taken;
	logic            accept;
	logic [XLEN-1:0] rd_n;
	logic            branch_n;
	logic [XLEN-1:0] pc_next_n;
	logic            read_n;
	logic            write_n;
	logic [2:0]      width_n;

	assign opcode    = i_instruction[6:0];
	assign funct3    = i_instruction[14:12];
	assign alt       = i_instruction[30];
	assign operand_b = (opcode == cpu_pkg::OP_REG) ? i_rs2 : i_imm;
	assign shamt     = operand_b[SHW-1:0];
	assign accept    = !i_hold && (i_tag != o_tag);

	function automatic logic [2:0] access_width(input logic [2:0] f3);
		case (f3)
			cpu_pkg::F3_B, cpu_pkg::F3_BU: return cpu_pkg::WIDTH_BYTE;
			cpu_pkg::F3_H, cpu_pkg::F3_HU: return cpu_pkg::WIDTH_HALF;
			default:                       return cpu_pkg::WIDTH_WORD;
		endcase
	endfunction

	always_comb begin
		case (funct3)
			cpu_pkg::F3_BEQ:  taken = (i_rs1 == i_rs2);
			cpu_pkg::F3_BNE:  taken = (i_rs1 != i_rs2);
			cpu_pkg::F3_BLT:  taken = ($signed(i_rs1) < $signed(i_rs2));
			cpu_pkg::F3_BGE:  taken = ($signed(i_rs1) >= $signed(i_rs2));
			cpu_pkg::F3_BLTU: taken = (i_rs1 < i_rs2);
			cpu_pkg::F3_BGEU: taken = (i_rs1 >= i_rs2);
			default:          taken = 1'b0;
		endcase
	end

	// ========================================================================
	// Operation by opcode
	// ========================================================================
	always_comb begin
		rd_n      = '0;
		branch_n  = i_branch;
		pc_next_n = i_pc + XLEN'(4);
		read_n    = 1'b0;
		write_n   = 1'b0;
		width_n   = '0;
		case (opcode)
			cpu_pkg::OP_LUI:   rd_n = i_imm;
			cpu_pkg::OP_AUIPC: rd_n = i_pc + i_imm;
			cpu_pkg::OP_JAL: begin
				rd_n      = i_pc + XLEN'(4);    // Link value.
				pc_next_n = i_pc + i_imm;
			end
			cpu_pkg::OP_JALR: begin
				rd_n      = i_pc + XLEN'(4);
				pc_next_n = (i_rs1 + i_imm) & ~XLEN'(1);
			end
			cpu_pkg::OP_BRANCH: begin
				pc_next_n = i_pc + i_imm;
				branch_n  = i_branch && taken;
			end
			cpu_pkg::OP_LOAD: begin
				read_n  = 1'b1;
				width_n = access_width(funct3);
			end
			cpu_pkg::OP_STORE: begin
				write_n = 1'b1;
				width_n = access_width(funct3);
				rd_n    = i_rs2;    // Store data.
			end
			cpu_pkg::OP_IMM, cpu_pkg::OP_REG: begin
				case (funct3)
					cpu_pkg::F3_ADD:
						rd_n = (opcode == cpu_pkg::OP_REG && alt) ? i_rs1 - operand_b :
							i_rs1 + operand_b;
					cpu_pkg::F3_SLL:  rd_n = i_rs1 << shamt;
					cpu_pkg::F3_SLT:  rd_n = XLEN'($signed(i_rs1) < $signed(operand_b));
					cpu_pkg::F3_SLTU: rd_n = XLEN'(i_rs1 < operand_b);
					cpu_pkg::F3_XOR:  rd_n = i_rs1 ^ operand_b;
					cpu_pkg::F3_SR:
						rd_n = alt ? XLEN'($signed(i_rs1) >>> shamt) : i_rs1 >> shamt;
					cpu_pkg::F3_OR:   rd_n = i_rs1 | operand_b;
					default:          rd_n = i_rs1 & operand_b;
				endcase
			end
			default: rd_n = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_tag       <= '0;
			o_branch    <= 1'b0;
			o_mem_read  <= 1'b0;
			o_mem_write <= 1'b0;
		end else if (accept) begin
			o_tag       <= i_tag;
			o_branch    <= branch_n;
			o_mem_read  <= read_n;
			o_mem_write <= write_n;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_inst_rd     <= i_inst_rd;
			o_rd          <= rd_n;
			o_pc_next     <= pc_next_n;
			o_mem_width   <= width_n;
			o_mem_signed  <= (funct3 == cpu_pkg::F3_B) || (funct3 == cpu_pkg::F3_H);
			o_mem_address <= i_rs1 + i_imm;
		end
	end

endmodule

/* logic/cpu_fetch.sv */
`timescale 1ns/1ps

module cpu_fetch #(
	parameter int XLEN  = 32,
	parameter int TAG_W = 8
) (
	input  logic             i_clock,
	input  logic             i_rst_n,
	input  logic             i_hold,
	input  logic             i_retire,
	input  logic [XLEN-1:0]  i_pc_next,
	input  logic [31:0]      i_imem_data,
	output logic [XLEN-1:0]  o_imem_addr,
	output logic [TAG_W-1:0] o_tag,
	output logic [XLEN-1:0]  o_pc,
	output logic [31:0]      o_instruction
);
	logic issuing;
	logic word_due;     // Memory word arrives this cycle.
	logic capture;

	assign capture = !i_hold && issuing && word_due;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			issuing     <= 1'b1;
			word_due    <= 1'b0;
			o_imem_addr <= XLEN'(cpu_pkg::RESET_PC);
			o_tag       <= '0;
		end else if (!i_hold) begin
			if (issuing) begin
				word_due <= !word_due;
				if (word_due) begin
					issuing <= 1'b0;
					o_tag   <= o_tag + 1'b1;    // Starts the instruction.
				end
			end else if (i_retire) begin
				issuing     <= 1'b1;
				o_imem_addr <= i_pc_next;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (capture) begin
			o_pc          <= o_imem_addr;
			o_instruction <= i_imem_data;
		end
	end

endmodule

/* logic/cpu_memory.sv */
`timescale 1ns/1ps

module cpu_memory #(
	parameter int XLEN  = 32,
	parameter int TAG_W = 8
) (
	input  logic             i_clock,
	input  logic             i_rst_n,
	input  logic             i_hold,
	input  logic [TAG_W-1:0] i_tag,
	input  logic [XLEN-1:0]  i_pc,
	input  logic [4:0]       i_inst_rd,
	input  logic [XLEN-1:0]  i_rd,
	input  logic             i_branch,
	input  logic [XLEN-1:0]  i_pc_next,
	input  logic             i_mem_read,
	input  logic             i_mem_write,
	input  logic [2:0]       i_mem_width,
	input  logic             i_mem_signed,
	input  logic [XLEN-1:0]  i_mem_address,
	output logic             o_dmem_read,
	output logic             o_dmem_write,
	output logic [2:0]       o_dmem_width,
	output logic [XLEN-1:0]  o_dmem_addr,
	output logic [XLEN-1:0]  o_dmem_wdata,
	input  logic [XLEN-1:0]  i_dmem_rdata,
	output logic             o_we,
	output logic [4:0]       o_rd_addr,
	output logic [XLEN-1:0]  o_rd_data,
	output logic             o_retire,
	output logic [XLEN-1:0]  o_retire_pc,
	output logic [4:0]       o_retire_rd,
	output logic [XLEN-1:0]  o_retire_value,
	output logic [XLEN-1:0]  o_pc_next
);
	logic [TAG_W-1:0] tag;
	logic             load_wait;
	logic             retire_q;
	logic             issue;
	logic             finish;
	logic [1:0]       lane;
	logic [XLEN-1:0]  lane_data;
	logic [XLEN-1:0]  load_value;

	assign issue  = !i_hold && (i_tag != tag) && !load_wait;
	assign finish = !i_hold && (load_wait || ((i_tag != tag) && !i_mem_read));
	assign lane   = i_mem_address[1:0];

	assign o_dmem_read  = issue && i_mem_read;
	assign o_dmem_write = issue && i_mem_write;
	assign o_dmem_width = i_mem_width;
	assign o_dmem_addr  = i_mem_address;
	assign o_dmem_wdata = i_rd << {lane, 3'b000};

	assign lane_data = i_dmem_rdata >> {lane, 3'b000};

	always_comb begin
		case (i_mem_width)
			cpu_pkg::WIDTH_BYTE:
				load_value = i_mem_signed ? XLEN'(signed'(lane_data[7:0])) : XLEN'(lane_data[7:0]);
			cpu_pkg::WIDTH_HALF:
				load_value = i_mem_signed ? XLEN'(signed'(lane_data[15:0])) :
					XLEN'(lane_data[15:0]);
			default: load_value = lane_data;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			tag       <= '0;
			load_wait <= 1'b0;
			retire_q  <= 1'b0;
		end else if (!i_hold) begin
			retire_q  <= finish;
			load_wait <= issue && i_mem_read;    // Read data next cycle.
			if (finish) begin
				tag <= i_tag;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (finish) begin
			o_retire_pc    <= i_pc;
			o_retire_rd    <= i_inst_rd;
			o_retire_value <= load_wait ? load_value : i_rd;
			o_pc_next      <= i_branch ? i_pc_next : i_pc + XLEN'(4);
		end
	end

	// Retire is not seen while held.
	assign o_retire  = retire_q && !i_hold;
	assign o_we      = o_retire && (o_retire_rd != 5'd0);
	assign o_rd_addr = o_retire_rd;
	assign o_rd_data = o_retire_value;

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

	// ========================================================================
	// Major opcodes
	// ========================================================================
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	// ========================================================================
	// funct3 codes
	// ========================================================================
	localparam logic [2:0] F3_ADD  = 3'b000;    // ADD, SUB and ADDI.
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;    // SRL or SRA by bit 30.
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// Access size in bytes.
	localparam logic [2:0] WIDTH_BYTE = 3'd1;
	localparam logic [2:0] WIDTH_HALF = 3'd2;
	localparam logic [2:0] WIDTH_WORD = 3'd4;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

/* logic/cpu_register_file.sv */
`timescale 1ns/1ps

module cpu_register_file #(
	parameter int XLEN = 32
) (
	input  logic            i_clock,
	input  logic            i_rst_n,
	input  logic [4:0]      i_rs1_addr,
	input  logic [4:0]      i_rs2_addr,
	output logic [XLEN-1:0] o_rs1_data,
	output logic [XLEN-1:0] o_rs2_data,
	input  logic            i_we,
	input  logic [4:0]      i_rd_addr,
	input  logic [XLEN-1:0] i_rd_data
);
	logic [XLEN-1:0] regs [1:31];

	assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_rd_addr != 5'd0)) begin
			regs[i_rd_addr] <= i_rd_data;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the cpu_core testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module cpu_core_tb -f cpu_core.f -o sim
out=$(./obj_dir/sim)
echo "$out"
if echo "$out" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1

/* verif/cpu_core_tb.sv */
`timescale 1ns/1ps

module cpu_core_tb;
	localparam int XLEN  = 32;
	localparam int TAG_W = 8;
	localparam logic [31:0] NOP = 32'h0000_0013;    // ADDI x0, x0, 0.

	logic            i_clock;
	logic            i_rst_n;
	logic            i_hold;
	logic [31:0]     i_imem_data;
	logic [XLEN-1:0] i_dmem_rdata;
	logic [XLEN-1:0] o_imem_addr;
	logic            o_dmem_read;
	logic            o_dmem_write;
	logic [2:0]      o_dmem_width;
	logic [XLEN-1:0] o_dmem_addr;
	logic [XLEN-1:0] o_dmem_wdata;
	logic            o_retire;
	logic [XLEN-1:0] o_retire_pc;
	logic [4:0]      o_retire_rd;
	logic [XLEN-1:0] o_retire_value;

	logic [31:0] imem [0:255];
	logic [7:0]  dmem [0:4095];
	logic [7:0]  shadow [0:4095];    // Expected data memory.
	logic [31:0] build_pc;
	logic [31:0] exp_pc [$];
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_val [$];
	logic [31:0] obs_pc [$];
	logic [4:0]  obs_rd [$];
	logic [31:0] obs_val [$];
	int          errors;
	int          checks;
	int          tests;
	int          run_cycles;
	int          run_limit;
	int          run_count;

	cpu_core #(.XLEN(XLEN), .TAG_W(TAG_W)) UUT (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_hold(i_hold),
		.o_imem_addr(o_imem_addr), .i_imem_data(i_imem_data),
		.o_dmem_read(o_dmem_read), .o_dmem_write(o_dmem_write),
		.o_dmem_width(o_dmem_width), .o_dmem_addr(o_dmem_addr),
		.o_dmem_wdata(o_dmem_wdata), .i_dmem_rdata(i_dmem_rdata),
		.o_retire(o_retire), .o_retire_pc(o_retire_pc),
		.o_retire_rd(o_retire_rd), .o_retire_value(o_retire_value)
	);

	initial i_clock = 1'b0;
	always #20 i_clock = ~i_clock;

	// ========================================================================
	// Memory models and retire monitor
	// ========================================================================
	always @(posedge i_clock) begin
		i_imem_data <= imem[o_imem_addr[9:2]];    // One-cycle read.
	end

	always @(posedge i_clock) begin
		if (o_dmem_read) begin
			i_dmem_rdata <= {dmem[{o_dmem_addr[11:2], 2'd3}], dmem[{o_dmem_addr[11:2], 2'd2}],
				dmem[{o_dmem_addr[11:2], 2'd1}], dmem[{o_dmem_addr[11:2], 2'd0}]};
		end
		if (o_dmem_write) begin
			for (int k = 0; k < 4; k++) begin
				if (k >= int'(o_dmem_addr[1:0]) &&
					k < int'(o_dmem_addr[1:0]) + int'(o_dmem_width)) begin
					dmem[{o_dmem_addr[11:2], 2'(k)}] = o_dmem_wdata[8*k +: 8];
				end
			end
		end
	end

	always @(posedge i_clock) begin
		if (i_rst_n && o_retire) begin
			obs_pc.push_back(o_retire_pc);
			obs_rd.push_back(o_retire_rd);
			obs_val.push_back(o_retire_value);
		end
		if (i_hold && o_retire) begin
			errors++;
			$display("Retire pulsed at %0t while hold was high", $time);
		end
	end

	always @(posedge i_clock) begin
		run_cycles++;
		if (run_cycles > run_limit) begin
			$display("Timeout: %0d of %0d instructions retired after %0d cycles",
				obs_pc.size(), run_count, run_cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// ========================================================================
	// Instruction encoders and reference rules
	// ========================================================================
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, cpu_pkg::OP_REG};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], cpu_pkg::OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::OP_JAL};
	endfunction

	function automatic logic cond_holds(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			cpu_pkg::F3_BEQ:  return a == b;
			cpu_pkg::F3_BNE:  return a != b;
			cpu_pkg::F3_BLT:  return $signed(a) < $signed(b);
			cpu_pkg::F3_BGE:  return $signed(a) >= $signed(b);
			cpu_pkg::F3_BLTU: return a < b;
			default:          return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] load_model(input logic [11:0] a, input logic [2:0] f3);
		logic [7:0] b0;
		logic [7:0] b1;
		b0 = shadow[a];
		b1 = shadow[a + 12'd1];
		case (f3)
			cpu_pkg::F3_B:  return {{24{b0[7]}}, b0};
			cpu_pkg::F3_BU: return {24'b0, b0};
			cpu_pkg::F3_H:  return {{16{b1[7]}}, b1, b0};
			cpu_pkg::F3_HU: return {16'b0, b1, b0};
			default:        return {shadow[a + 12'd3], shadow[a + 12'd2], b1, b0};
		endcase
	endfunction

	task automatic store_model(input logic [11:0] a, input logic [2:0] f3,
		input logic [31:0] data);
		shadow[a] = data[7:0];
		if (f3 != cpu_pkg::F3_B) begin
			shadow[a + 12'd1] = data[15:8];
		end
		if (f3 == cpu_pkg::F3_W) begin
			shadow[a + 12'd2] = data[23:16];
			shadow[a + 12'd3] = data[31:24];
		end
	endtask

	// ========================================================================
	// Program building and running
	// ========================================================================
	task automatic start_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = NOP;
		end
		for (int i = 0; i < 4096; i++) begin
			dmem[i]   = 8'(i) ^ 8'(i >> 4) ^ 8'h5a;
			shadow[i] = dmem[i];
		end
		exp_pc.delete();
		exp_rd.delete();
		exp_val.delete();
		build_pc = cpu_pkg::RESET_PC;
	endtask

	task automatic emit(input logic [31:0] instr, input logic [4:0] rd, input logic [31:0] val);
		imem[build_pc[9:2]] = instr;
		exp_pc.push_back(build_pc);
		exp_rd.push_back(rd);
		exp_val.push_back(val);
		build_pc += 32'd4;
	endtask

	task automatic skip_slot();
		imem[build_pc[9:2]] = enc_i(12'd1, 5'd0, cpu_pkg::F3_ADD, 5'd31, cpu_pkg::OP_IMM);
		build_pc += 32'd4;    // Never retires.
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) >> 12;
		emit({hi[19:0], rd, cpu_pkg::OP_LUI}, rd, {hi[19:0], 12'b0});
		emit(enc_i(v[11:0], rd, cpu_pkg::F3_ADD, rd, cpu_pkg::OP_IMM), rd, v);
	endtask

	task automatic run_program(input bit with_hold, input int budget);
		int n;
		n          = exp_pc.size();
		run_count  = n;
		run_limit  = 6 * n + 200;
		run_cycles = 0;
		@(negedge i_clock);
		i_rst_n = 1'b0;
		i_hold  = 1'b0;
		obs_pc.delete();
		obs_rd.delete();
		obs_val.delete();
		repeat (2) @(negedge i_clock);
		i_rst_n = 1'b1;
		while (obs_pc.size() < n) begin
			@(negedge i_clock);
			if (with_hold && budget > 0 && $urandom_range(3, 0) == 0) begin
				i_hold = 1'b1;
				budget--;
			end else begin
				i_hold = 1'b0;
			end
		end
		i_hold = 1'b1;    // Park the core.
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] got);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Fail %0t %s: expected %h, got %h", $time, name, expected, got);
		end
	endtask

	task automatic compare_retires();
		for (int i = 0; i < exp_pc.size(); i++) begin
			check_eq("o_retire_pc", exp_pc[i], obs_pc[i]);
			check_eq("o_retire_rd", 32'(exp_rd[i]), 32'(obs_rd[i]));
			if (exp_rd[i] != 5'd0) begin
				check_eq("o_retire_value", exp_val[i], obs_val[i]);
			end
		end
	endtask

	task automatic check_retires(input string name, input int errs_before);
		compare_retires();
		tests++;
		$display("Test %s: %0d errors", name, errors - errs_before);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================
	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [31:0] simm;
		logic [4:0]  sh;
		int          e0;
		e0   = errors;
		a    = $urandom;
		b    = $urandom;
		imm  = 12'($urandom);
		simm = {{20{imm[11]}}, imm};
		sh   = b[4:0];
		start_program();
		load_const(5'd1, a);
		load_const(5'd2, b);
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_ADD, 5'd3), 5'd3, a + b);
		emit(enc_r(7'h20, 5'd2, 5'd1, cpu_pkg::F3_ADD, 5'd3), 5'd3, a - b);
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_SLT, 5'd3), 5'd3, 32'($signed(a) < $signed(b)));
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_SLTU, 5'd3), 5'd3, 32'(a < b));
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_XOR, 5'd3), 5'd3, a ^ b);
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_OR, 5'd3), 5'd3, a | b);
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_AND, 5'd3), 5'd3, a & b);
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_SLL, 5'd3), 5'd3, a << sh);
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_SR, 5'd3), 5'd3, a >> sh);
		emit(enc_r(7'h20, 5'd2, 5'd1, cpu_pkg::F3_SR, 5'd3), 5'd3, 32'($signed(a) >>> sh));
		emit(enc_i(imm, 5'd1, cpu_pkg::F3_ADD, 5'd4, cpu_pkg::OP_IMM), 5'd4, a + simm);
		emit(enc_i(imm, 5'd1, cpu_pkg::F3_SLT, 5'd4, cpu_pkg::OP_IMM), 5'd4,
			32'($signed(a) < $signed(simm)));
		emit(enc_i(imm, 5'd1, cpu_pkg::F3_SLTU, 5'd4, cpu_pkg::OP_IMM), 5'd4, 32'(a < simm));
		emit(enc_i(imm, 5'd1, cpu_pkg::F3_XOR, 5'd4, cpu_pkg::OP_IMM), 5'd4, a ^ simm);
		emit(enc_i(imm, 5'd1, cpu_pkg::F3_OR, 5'd4, cpu_pkg::OP_IMM), 5'd4, a | simm);
		emit(enc_i(imm, 5'd1, cpu_pkg::F3_AND, 5'd4, cpu_pkg::OP_IMM), 5'd4, a & simm);
		emit(enc_i({7'h00, sh}, 5'd1, cpu_pkg::F3_SLL, 5'd4, cpu_pkg::OP_IMM), 5'd4, a << sh);
		emit(enc_i({7'h00, sh}, 5'd1, cpu_pkg::F3_SR, 5'd4, cpu_pkg::OP_IMM), 5'd4, a >> sh);
		emit(enc_i({7'h20, sh}, 5'd1, cpu_pkg::F3_SR, 5'd4, cpu_pkg::OP_IMM), 5'd4,
			32'($signed(a) >>> sh));
		// Write to x0, then read x0 back.
		emit(enc_i(12'd5, 5'd0, cpu_pkg::F3_ADD, 5'd0, cpu_pkg::OP_IMM), 5'd0, 32'd0);
		emit(enc_r(7'h00, 5'd1, 5'd0, cpu_pkg::F3_ADD, 5'd5), 5'd5, a);
		run_program(1'b0, 0);
		check_retires("alu", e0);
	endtask

	task automatic test_upper();
		logic [19:0] u;
		int          e0;
		e0 = errors;
		u  = 20'($urandom);
		start_program();
		emit({u, 5'd5, cpu_pkg::OP_LUI}, 5'd5, {u, 12'b0});
		emit({u, 5'd6, cpu_pkg::OP_AUIPC}, 5'd6, build_pc + {u, 12'b0});
		run_program(1'b0, 0);
		check_retires("upper", e0);
	endtask

	task automatic branch_step(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] va, input logic [31:0] vb);
		emit(enc_b(13'd8, rs2, rs1, f3), 5'd0, 32'd0);
		if (cond_holds(f3, va, vb)) begin
			skip_slot();
		end
	endtask

	task automatic test_branch();
		logic [31:0] a;
		logic [31:0] b;
		logic [2:0]  f3s [6];
		int          e0;
		e0  = errors;
		a   = -(32'($urandom_range(999, 0)) + 32'd1);
		b   = 32'($urandom_range(999, 0));
		f3s = '{cpu_pkg::F3_BEQ, cpu_pkg::F3_BNE, cpu_pkg::F3_BLT, cpu_pkg::F3_BGE,
			cpu_pkg::F3_BLTU, cpu_pkg::F3_BGEU};
		start_program();
		load_const(5'd1, a);
		load_const(5'd2, b);
		load_const(5'd3, a);
		for (int i = 0; i < 6; i++) begin
			branch_step(f3s[i], 5'd1, 5'd2, a, b);
			branch_step(f3s[i], 5'd1, 5'd3, a, a);
		end
		emit(enc_i(12'd7, 5'd0, cpu_pkg::F3_ADD, 5'd7, cpu_pkg::OP_IMM), 5'd7, 32'd7);
		run_program(1'b0, 0);
		check_retires("branch", e0);
	endtask

	task automatic test_jump();
		logic [31:0] p;
		int          e0;
		e0 = errors;
		start_program();
		p = build_pc;
		emit(enc_j(21'd12, 5'd1), 5'd1, p + 32'd4);
		skip_slot();
		skip_slot();
		emit(enc_i(12'h100, 5'd0, cpu_pkg::F3_ADD, 5'd5, cpu_pkg::OP_IMM), 5'd5, 32'h100);
		p = build_pc;
		// Target 0x105 has its low bit cleared.
		emit(enc_i(12'd5, 5'd5, 3'b000, 5'd2, cpu_pkg::OP_JALR), 5'd2, p + 32'd4);
		build_pc = 32'h104;
		emit(enc_i(12'd6, 5'd0, cpu_pkg::F3_ADD, 5'd6, cpu_pkg::OP_IMM), 5'd6, 32'd6);
		run_program(1'b0, 0);
		check_retires("jump", e0);
	endtask

	task automatic emit_store(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [11:0] off, input logic [31:0] base, input logic [31:0] data);
		emit(enc_s(off, 5'd2, rs1, f3), 5'd0, 32'd0);
		store_model(12'(base + 32'(off)), f3, data);
	endtask

	task automatic emit_load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] off, input logic [31:0] base);
		emit(enc_i(off, rs1, f3, rd, cpu_pkg::OP_LOAD), rd, load_model(12'(base + 32'(off)), f3));
	endtask

	task automatic test_load_store();
		logic [31:0] r;
		int          e0;
		e0 = errors;
		r  = $urandom;
		start_program();
		load_const(5'd1, 32'h200);
		load_const(5'd2, r);
		emit_store(cpu_pkg::F3_W, 5'd1, 12'd0, 32'h200, r);
		emit_store(cpu_pkg::F3_H, 5'd1, 12'd6, 32'h200, r);
		emit_store(cpu_pkg::F3_B, 5'd1, 12'd9, 32'h200, r);
		emit_store(cpu_pkg::F3_B, 5'd1, 12'd15, 32'h200, r);
		emit_load(cpu_pkg::F3_W, 5'd3, 5'd1, 12'd0, 32'h200);
		emit_load(cpu_pkg::F3_H, 5'd4, 5'd1, 12'd6, 32'h200);
		emit_load(cpu_pkg::F3_HU, 5'd5, 5'd1, 12'd6, 32'h200);
		emit_load(cpu_pkg::F3_B, 5'd6, 5'd1, 12'd9, 32'h200);
		emit_load(cpu_pkg::F3_BU, 5'd7, 5'd1, 12'd15, 32'h200);
		emit_load(cpu_pkg::F3_B, 5'd8, 5'd1, 12'd1, 32'h200);
		emit_load(cpu_pkg::F3_HU, 5'd9, 5'd1, 12'd2, 32'h200);
		emit_load(cpu_pkg::F3_W, 5'd10, 5'd1, 12'd4, 32'h200);
		emit_load(cpu_pkg::F3_BU, 5'd11, 5'd1, 12'd9, 32'h200);
		run_program(1'b0, 0);
		for (int i = 12'h200; i < 12'h210; i++) begin
			check_eq("dmem byte", 32'(shadow[i]), 32'(dmem[i]));
		end
		check_retires("load_store", e0);
	endtask

	task automatic test_hold();
		logic [31:0] a;
		logic [31:0] b;
		int          e0;
		e0 = errors;
		a  = $urandom;
		b  = $urandom;
		start_program();
		load_const(5'd1, a);
		load_const(5'd2, b);
		emit(enc_r(7'h20, 5'd2, 5'd1, cpu_pkg::F3_ADD, 5'd3), 5'd3, a - b);
		emit(enc_i(12'h300, 5'd0, cpu_pkg::F3_ADD, 5'd10, cpu_pkg::OP_IMM), 5'd10, 32'h300);
		emit_store(cpu_pkg::F3_W, 5'd10, 12'd0, 32'h300, b);
		emit_load(cpu_pkg::F3_H, 5'd4, 5'd10, 12'd2, 32'h300);
		emit_load(cpu_pkg::F3_W, 5'd5, 5'd10, 12'd0, 32'h300);
		emit(enc_b(13'd8, 5'd2, 5'd5, cpu_pkg::F3_BEQ), 5'd0, 32'd0);
		skip_slot();
		emit(enc_r(7'h00, 5'd2, 5'd1, cpu_pkg::F3_XOR, 5'd6), 5'd6, a ^ b);
		// Same expected sequence with and without hold.
		run_program(1'b0, 0);
		compare_retires();
		run_program(1'b1, 30);
		check_retires("hold", e0);
	endtask

	initial begin
		void'($urandom(32'h284d_c516));
		i_rst_n      = 1'b0;
		i_hold       = 1'b0;
		i_imem_data  <= NOP;
		i_dmem_rdata <= '0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		test_alu();
		test_upper();
		test_branch();
		test_jump();
		test_load_store();
		test_hold();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
